//--- all.f
common/exec_opc_pkg.sv
common/exec_wb_pkg.sv
common/exec_opnd_if.sv
common/exec_wb_if.sv
alu/alu_1clk.sv
muldiv/mul_pipe.sv
muldiv/div_serial.sv
rtl/exec_wb_mux.sv
rtl/exec_top.sv
test/tb_exec.sv

//--- alu/alu_1clk.sv
`timescale 1ns/1ps
/* one-cycle ALU with its own write-back register and compare flag pair
   OPERAND_WIDTH must be a power of two and the shift amount is the low bits of op_b */
module alu_1clk
  import exec_opc_pkg::*;
  import exec_wb_pkg::*;
#(
  parameter int OPERAND_WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     padv_wb_i,
  input  logic                     pipeline_flush_i,
  input  logic                     insn_1clk_i,
  input  alu_op_e                  alu_op_i,
  input  cmp_op_e                  cmp_op_i,
  input  logic [OPERAND_WIDTH-1:0] rfa_i,
  input  logic [OPERAND_WIDTH-1:0] rfb_i,
  input  logic [OPERAND_WIDTH-1:0] immediate_i,
  input  logic                     immediate_sel_i,
  input  logic                     carry_i,
  input  logic                     flag_i,
  exec_opnd_if.src                 opnd,
  exec_wb_if.unit                  wb,
  output logic                     wb_int_flag_set_o,
  output logic                     wb_int_flag_clear_o
);

  localparam int W   = OPERAND_WIDTH;
  localparam int SHW = $clog2(OPERAND_WIDTH);

  logic [W-1:0]   op_a;
  logic [W-1:0]   op_b;
  logic           do_sub;
  logic           carry_in;
  logic [W-1:0]   b_mux;
  logic [W-1:0]   sum;
  logic           cout;
  logic           s_ovf;
  logic           is_add;
  logic           is_setflag;
  logic           a_eq_b;
  logic           a_lts_b;
  logic           a_ltu_b;
  logic           flag_set;
  logic [W-1:0]   shift_lsw;
  logic [W-1:0]   shift_msw;
  logic [2*W-1:0] shift_wide;
  logic [W-1:0]   shift_res;
  logic [W-1:0]   ff1_pos;
  logic [W-1:0]   fl1_pos;
  logic [3:0]     logic_lut;
  logic [W-1:0]   logic_res;
  logic [W-1:0]   alu_res;
  logic [W-1:0]   result_q;
  logic           rdy_q;

  assign op_a = rfa_i;
  assign op_b = immediate_sel_i ? immediate_i : rfb_i;

  assign opnd.op_a = op_a;
  assign opnd.op_b = op_b;
  assign opnd.rfa  = rfa_i;
  assign opnd.rfb  = rfb_i;

  // SETFLAG goes through the adder as a subtract
  assign do_sub   = (alu_op_i == SUB) || (alu_op_i == SETFLAG);
  assign carry_in = do_sub | ((alu_op_i == ADDC) & carry_i);
  assign b_mux    = do_sub ? ~op_b : op_b;
  assign {cout, sum} = op_a + b_mux + W'(carry_in);

  // operand signs equal and result sign differs
  assign s_ovf = (op_a[W-1] == b_mux[W-1]) & (op_a[W-1] ^ sum[W-1]);

  assign is_add     = insn_1clk_i & (alu_op_i inside {ADD, ADDC, SUB});
  assign is_setflag = insn_1clk_i & (alu_op_i == SETFLAG);

  // carry is the raw carry-out on SUB too
  assign wb.cy_upd = '{set: is_add & cout, clear: is_add & ~cout};
  assign wb.ov_upd = '{set: is_add & s_ovf, clear: is_add & ~s_ovf};

  assign a_eq_b  = (op_a == op_b);
  assign a_lts_b = sum[W-1] ^ s_ovf;
  assign a_ltu_b = ~cout;           // borrow out of a - b

  always_comb begin
    case (cmp_op_i)
      EQ:      flag_set = a_eq_b;
      NE:      flag_set = ~a_eq_b;
      GTU:     flag_set = ~(a_eq_b | a_ltu_b);
      GTS:     flag_set = ~(a_eq_b | a_lts_b);
      GEU:     flag_set = ~a_ltu_b;
      GES:     flag_set = ~a_lts_b;
      LTU:     flag_set = a_ltu_b;
      LTS:     flag_set = a_lts_b;
      LEU:     flag_set = a_eq_b | a_ltu_b;
      LES:     flag_set = a_eq_b | a_lts_b;
      default: flag_set = 1'b0;
    endcase
  end

  function automatic logic [W-1:0] reverse(input logic [W-1:0] in);
    logic [W-1:0] out;
    for (int i = 0; i < W; i++) begin
      out[W-1-i] = in[i];
    end
    return out;
  endfunction

  // left shift done as a right shift on reversed bits
  assign shift_lsw  = (alu_op_i == SLL) ? reverse(op_a) : op_a;
  assign shift_msw  = (alu_op_i == SRA) ? {W{op_a[W-1]}} :
                      (alu_op_i == ROR) ? op_a : '0;
  assign shift_wide = {shift_msw, shift_lsw} >> op_b[SHW-1:0];
  assign shift_res  = (alu_op_i == SLL) ? reverse(shift_wide[W-1:0]) : shift_wide[W-1:0];

  always_comb begin
    ff1_pos = '0;
    fl1_pos = '0;
    for (int i = W - 1; i >= 0; i--) begin
      if (op_a[i])
        ff1_pos = W'(i + 1);  // lowest set bit wins
    end
    for (int i = 0; i < W; i++) begin
      if (op_a[i])
        fl1_pos = W'(i + 1);  // highest set bit wins
    end
  end

  // truth table indexed by {a, b}
  always_comb begin
    case (alu_op_i)
      AND:     logic_lut = 4'b1000;
      OR:      logic_lut = 4'b1110;
      XOR:     logic_lut = 4'b0110;
      default: logic_lut = 4'b0000;
    endcase
    for (int i = 0; i < W; i++) begin
      logic_res[i] = logic_lut[{op_a[i], op_b[i]}];
    end
  end

  always_comb begin
    case (alu_op_i)
      ADD, ADDC, SUB:     alu_res = sum;
      AND, OR, XOR:       alu_res = logic_res;
      SLL, SRL, SRA, ROR: alu_res = shift_res;
      FF1:                alu_res = ff1_pos;
      FL1:                alu_res = fl1_pos;
      CMOV:               alu_res = flag_i ? op_a : op_b;
      MOVHI:              alu_res = immediate_i;
      default:            alu_res = '0;  // SETFLAG and NOP write zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (insn_1clk_i && padv_wb_i)
      result_q <= alu_res;
  end

  always_ff @(posedge clk) begin
    if (rst || pipeline_flush_i) begin
      rdy_q               <= 1'b0;
      wb_int_flag_set_o   <= 1'b0;
      wb_int_flag_clear_o <= 1'b0;
    end else if (padv_wb_i) begin
      rdy_q               <= insn_1clk_i;
      wb_int_flag_set_o   <= is_setflag & flag_set;
      wb_int_flag_clear_o <= is_setflag & ~flag_set;
    end
  end

  assign wb.valid  = insn_1clk_i;
  assign wb.rdy    = rdy_q;
  assign wb.result = result_q;

  a_int_flag_excl: assert property (@(posedge clk) disable iff (rst)
    !(wb_int_flag_set_o && wb_int_flag_clear_o));

endmodule

//--- common/exec_opc_pkg.sv
/* opcodes of the one-cycle ALU and compare conditions of SETFLAG
   both enums are 4 bits wide and decoded in full by the ALU */
package exec_opc_pkg;

  // one-cycle operation
  typedef enum logic [3:0] {
    ADD,
    ADDC,     // add with carry-in
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    ROR,      // rotate right
    FF1,      // 1-based position of lowest set bit
    FL1,      // 1-based position of highest set bit
    CMOV,
    MOVHI,
    SETFLAG,
    NOP
  } alu_op_e;

  // SETFLAG condition, S suffix is signed
  typedef enum logic [3:0] {
    EQ, NE,
    GTU, GTS,
    GEU, GES,
    LTU, LTS,
    LEU, LES
  } cmp_op_e;

endpackage

//--- common/exec_opnd_if.sv
`timescale 1ns/1ps
/* selected operands handed from the ALU to the multi-cycle units
   op_b already has the immediate select applied */
interface exec_opnd_if #(
  parameter int OPERAND_WIDTH = 32
) ();

  logic [OPERAND_WIDTH-1:0] op_a;   // always rfa
  logic [OPERAND_WIDTH-1:0] op_b;   // immediate or rfb
  logic [OPERAND_WIDTH-1:0] rfa;
  logic [OPERAND_WIDTH-1:0] rfb;

  modport src (output op_a, output op_b, output rfa, output rfb);
  modport dst (input op_a, input op_b, input rfa, input rfb);

endinterface

//--- common/exec_wb_if.sv
`timescale 1ns/1ps
/* one execution unit towards the write-back mux
   rdy and result are registered, valid and the flag updates are not */
interface exec_wb_if
  import exec_wb_pkg::*;
#(
  parameter int OPERAND_WIDTH = 32
) ();

  logic                     valid;   // result finished, waiting for advance
  logic                     rdy;     // result register holds a written-back value
  logic [OPERAND_WIDTH-1:0] result;
  flag_upd_t                cy_upd;  // qualified by valid
  flag_upd_t                ov_upd;

  modport unit (
    output valid, output rdy, output result,
    output cy_upd, output ov_upd
  );

  modport sink (
    input valid, input rdy, input result,
    input cy_upd, input ov_upd
  );

endinterface

//--- common/exec_wb_pkg.sv
/* write-back flag update type and divider constants
   a flag update never has set and clear high together */
package exec_wb_pkg;

  // flag left untouched when both bits are low
  typedef struct packed {
    logic set;
    logic clear;
  } flag_upd_t;

  localparam flag_upd_t FLAG_KEEP = '{set: 1'b0, clear: 1'b0};

  // divider iteration counter, wide enough for operands up to 32 bits
  localparam int DIV_CNT_W = 6;

endpackage

//--- muldiv/div_serial.sv
`timescale 1ns/1ps
/* serial restoring divider with one quotient bit per cycle and no remainder output
   divide by zero flags overflow when signed and carry when unsigned */
module div_serial
  import exec_wb_pkg::*;
#(
  parameter int OPERAND_WIDTH = 32
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     padv_wb_i,
  input  logic     pipeline_flush_i,
  input  logic     op_div_i,
  input  logic     div_signed_i,
  exec_opnd_if.dst opnd,
  exec_wb_if.unit  wb,
  output logic     div_busy_o,
  output logic     take_op_div_o
);

  localparam int W = OPERAND_WIDTH;

  logic                 div_valid;
  logic [DIV_CNT_W-1:0] div_count;
  logic                 sign_a;
  logic                 sign_b;
  logic [W-1:0]         div_n;      // dividend that shifts into the quotient
  logic [W-1:0]         div_d;
  logic [W-1:0]         div_r;      // partial remainder
  logic                 div_neg;
  logic                 div_signed_q;
  logic                 dbz_q;
  logic [W+1:0]         div_sub;
  logic [W-1:0]         div_res;
  logic [W-1:0]         result_q;
  logic                 rdy_q;

  assign take_op_div_o = op_div_i & (div_valid ? padv_wb_i : ~div_busy_o);

  always_ff @(posedge clk) begin
    if (rst || pipeline_flush_i) begin
      div_valid  <= 1'b0;
      div_busy_o <= 1'b0;
      div_count  <= '0;
    end else if (take_op_div_o) begin
      div_valid  <= 1'b0;
      div_busy_o <= 1'b1;
      div_count  <= DIV_CNT_W'(W);
    end else if (div_valid && padv_wb_i) begin
      div_valid <= 1'b0;
    end else if (div_busy_o) begin
      if (div_count == DIV_CNT_W'(1)) begin
        div_valid  <= 1'b1;
        div_busy_o <= 1'b0;
      end
      div_count <= div_count - 1'b1;
    end
  end

  assign sign_a = opnd.rfa[W-1] & div_signed_i;
  assign sign_b = opnd.rfb[W-1] & div_signed_i;

  // two extra bits keep the trial subtract sign exact
  assign div_sub = {1'b0, div_r, div_n[W-1]} - {2'b00, div_d};

  always_ff @(posedge clk) begin
    if (take_op_div_o) begin
      div_n        <= (opnd.rfa ^ {W{sign_a}}) + W'(sign_a);
      div_d        <= (opnd.rfb ^ {W{sign_b}}) + W'(sign_b);
      div_r        <= '0;
      div_neg      <= sign_a ^ sign_b;
      div_signed_q <= div_signed_i;
      dbz_q        <= ~(|opnd.rfb);
    end else if (div_busy_o) begin
      if (!div_sub[W+1]) begin  // fits so keep the difference
        div_r <= div_sub[W-1:0];
        div_n <= {div_n[W-2:0], 1'b1};
      end else begin
        div_r <= {div_r[W-2:0], div_n[W-1]};
        div_n <= {div_n[W-2:0], 1'b0};
      end
    end
  end

  assign div_res = (div_n ^ {W{div_neg}}) + W'(div_neg);

  always_ff @(posedge clk) begin
    if (div_valid && padv_wb_i)
      result_q <= div_res;
  end

  always_ff @(posedge clk) begin
    if (rst || pipeline_flush_i)
      rdy_q <= 1'b0;
    else if (padv_wb_i)
      rdy_q <= div_valid;
  end

  assign wb.valid  = div_valid;
  assign wb.rdy    = rdy_q;
  assign wb.result = result_q;
  assign wb.ov_upd = '{set:   div_valid & div_signed_q & dbz_q,
                       clear: div_valid & div_signed_q & ~dbz_q};
  assign wb.cy_upd = '{set:   div_valid & ~div_signed_q & dbz_q,
                       clear: div_valid & ~div_signed_q & ~dbz_q};

  a_busy_valid: assert property (@(posedge clk) disable iff (rst)
    !(div_busy_o && div_valid));

endmodule

//--- muldiv/mul_pipe.sv
`timescale 1ns/1ps
/* three-stage multiplier keeping the low OPERAND_WIDTH bits of the product
   OPERAND_WIDTH must be even and the whole pipe freezes under a write-back stall */
module mul_pipe
  import exec_wb_pkg::*;
#(
  parameter int OPERAND_WIDTH = 32
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     padv_wb_i,
  input  logic     pipeline_flush_i,
  input  logic     op_mul_i,
  exec_opnd_if.dst opnd,
  exec_wb_if.unit  wb,
  output logic     mul_busy_o,
  output logic     take_op_mul_o
);

  localparam int W  = OPERAND_WIDTH;
  localparam int HW = OPERAND_WIDTH / 2;

  logic          mul_adv;
  logic          s1_rdy;
  logic          s2_rdy;
  logic [HW-1:0] s1_al;
  logic [HW-1:0] s1_ah;
  logic [HW-1:0] s1_bl;
  logic [HW-1:0] s1_bh;
  logic [W-1:0]  s2_albl;
  logic [W-1:0]  s2_ahbl;
  logic [W-1:0]  s2_bhal;
  logic [W-1:0]  s3_sum;
  logic [W-1:0]  result_q;
  logic          rdy_q;

  // last stage empty or being drained
  assign mul_adv       = ~s2_rdy | padv_wb_i;
  assign mul_busy_o    = op_mul_i & ~mul_adv;
  assign take_op_mul_o = op_mul_i & mul_adv;

  always_ff @(posedge clk) begin
    if (mul_adv) begin
      s1_al   <= opnd.op_a[HW-1:0];
      s1_ah   <= opnd.op_a[W-1:HW];
      s1_bl   <= opnd.op_b[HW-1:0];
      s1_bh   <= opnd.op_b[W-1:HW];
      s2_albl <= W'(s1_al) * W'(s1_bl);
      s2_ahbl <= W'(s1_ah) * W'(s1_bl);
      s2_bhal <= W'(s1_bh) * W'(s1_al);
    end
  end

  // ah*bh only lands above the kept bits
  assign s3_sum = {s2_bhal[HW-1:0], {HW{1'b0}}} +
                  {s2_ahbl[HW-1:0], {HW{1'b0}}} +
                  s2_albl;

  always_ff @(posedge clk) begin
    if (rst || pipeline_flush_i) begin
      s1_rdy <= 1'b0;
      s2_rdy <= 1'b0;
      rdy_q  <= 1'b0;
    end else begin
      if (mul_adv) begin
        s1_rdy <= op_mul_i;
        s2_rdy <= s1_rdy;
      end
      if (padv_wb_i)
        rdy_q <= s2_rdy;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_rdy && padv_wb_i)
      result_q <= s3_sum;
  end

  assign wb.valid  = s2_rdy;
  assign wb.rdy    = rdy_q;
  assign wb.result = result_q;
  assign wb.cy_upd = FLAG_KEEP;  // multiply leaves carry and overflow alone
  assign wb.ov_upd = FLAG_KEEP;

  a_take_busy: assert property (@(posedge clk) disable iff (rst)
    !(take_op_mul_o && mul_busy_o));

endmodule

//--- rtl/exec_top.sv
`timescale 1ns/1ps
/* integer execute stage: one-cycle ALU, pipelined multiplier, serial divider
   OPERAND_WIDTH must be even, a power of two and at most 32 */
module exec_top
  import exec_opc_pkg::*;
#(
  parameter int OPERAND_WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     padv_wb_i,
  input  logic                     pipeline_flush_i,
  input  logic [OPERAND_WIDTH-1:0] rfa_i,
  input  logic [OPERAND_WIDTH-1:0] rfb_i,
  input  logic [OPERAND_WIDTH-1:0] immediate_i,
  input  logic                     immediate_sel_i,
  input  logic                     insn_1clk_i,
  input  alu_op_e                  alu_op_i,
  input  cmp_op_e                  cmp_op_i,
  input  logic                     carry_i,
  input  logic                     flag_i,
  input  logic                     op_mul_i,
  output logic                     mul_busy_o,
  output logic                     take_op_mul_o,
  input  logic                     op_div_i,
  input  logic                     div_signed_i,
  output logic                     div_busy_o,
  output logic                     take_op_div_o,
  output logic                     exec_valid_o,
  output logic [OPERAND_WIDTH-1:0] wb_result_o,
  output logic                     wb_int_flag_set_o,
  output logic                     wb_int_flag_clear_o,
  output logic                     wb_carry_set_o,
  output logic                     wb_carry_clear_o,
  output logic                     wb_overflow_set_o,
  output logic                     wb_overflow_clear_o
);

  exec_opnd_if #(.OPERAND_WIDTH(OPERAND_WIDTH)) opnd_if ();
  exec_wb_if   #(.OPERAND_WIDTH(OPERAND_WIDTH)) alu_wb_if ();
  exec_wb_if   #(.OPERAND_WIDTH(OPERAND_WIDTH)) mul_wb_if ();
  exec_wb_if   #(.OPERAND_WIDTH(OPERAND_WIDTH)) div_wb_if ();

  alu_1clk #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_alu (
    .clk                 (clk),
    .rst                 (rst),
    .padv_wb_i           (padv_wb_i),
    .pipeline_flush_i    (pipeline_flush_i),
    .insn_1clk_i         (insn_1clk_i),
    .alu_op_i            (alu_op_i),
    .cmp_op_i            (cmp_op_i),
    .rfa_i               (rfa_i),
    .rfb_i               (rfb_i),
    .immediate_i         (immediate_i),
    .immediate_sel_i     (immediate_sel_i),
    .carry_i             (carry_i),
    .flag_i              (flag_i),
    .opnd                (opnd_if.src),
    .wb                  (alu_wb_if.unit),
    .wb_int_flag_set_o   (wb_int_flag_set_o),
    .wb_int_flag_clear_o (wb_int_flag_clear_o)
  );

  mul_pipe #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_mul (
    .clk              (clk),
    .rst              (rst),
    .padv_wb_i        (padv_wb_i),
    .pipeline_flush_i (pipeline_flush_i),
    .op_mul_i         (op_mul_i),
    .opnd             (opnd_if.dst),
    .wb               (mul_wb_if.unit),
    .mul_busy_o       (mul_busy_o),
    .take_op_mul_o    (take_op_mul_o)
  );

  div_serial #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_div (
    .clk              (clk),
    .rst              (rst),
    .padv_wb_i        (padv_wb_i),
    .pipeline_flush_i (pipeline_flush_i),
    .op_div_i         (op_div_i),
    .div_signed_i     (div_signed_i),
    .opnd             (opnd_if.dst),
    .wb               (div_wb_if.unit),
    .div_busy_o       (div_busy_o),
    .take_op_div_o    (take_op_div_o)
  );

  exec_wb_mux #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_wb_mux (
    .clk                 (clk),
    .rst                 (rst),
    .padv_wb_i           (padv_wb_i),
    .pipeline_flush_i    (pipeline_flush_i),
    .alu                 (alu_wb_if.sink),
    .mul                 (mul_wb_if.sink),
    .div                 (div_wb_if.sink),
    .exec_valid_o        (exec_valid_o),
    .wb_carry_set_o      (wb_carry_set_o),
    .wb_carry_clear_o    (wb_carry_clear_o),
    .wb_overflow_set_o   (wb_overflow_set_o),
    .wb_overflow_clear_o (wb_overflow_clear_o),
    .wb_result_o         (wb_result_o)
  );

endmodule

//--- rtl/exec_wb_mux.sv
`timescale 1ns/1ps
/* write-back result select and registered carry and overflow updates
   relies on the units never holding rdy together */
module exec_wb_mux
  import exec_wb_pkg::*;
#(
  parameter int OPERAND_WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     padv_wb_i,
  input  logic                     pipeline_flush_i,
  exec_wb_if.sink                  alu,
  exec_wb_if.sink                  mul,
  exec_wb_if.sink                  div,
  output logic                     exec_valid_o,
  output logic                     wb_carry_set_o,
  output logic                     wb_carry_clear_o,
  output logic                     wb_overflow_set_o,
  output logic                     wb_overflow_clear_o,
  output logic [OPERAND_WIDTH-1:0] wb_result_o
);

  localparam int W = OPERAND_WIDTH;

  flag_upd_t cy_any;
  flag_upd_t ov_any;

  assign exec_valid_o = alu.valid | mul.valid | div.valid;

  // and-or select, zero when nothing is ready
  assign wb_result_o = ({W{alu.rdy}} & alu.result) |
                       ({W{mul.rdy}} & mul.result) |
                       ({W{div.rdy}} & div.result);

  assign cy_any = alu.cy_upd | mul.cy_upd | div.cy_upd;
  assign ov_any = alu.ov_upd | mul.ov_upd | div.ov_upd;

  always_ff @(posedge clk) begin
    if (rst || pipeline_flush_i) begin
      wb_carry_set_o      <= 1'b0;
      wb_carry_clear_o    <= 1'b0;
      wb_overflow_set_o   <= 1'b0;
      wb_overflow_clear_o <= 1'b0;
    end else if (padv_wb_i) begin
      wb_carry_set_o      <= cy_any.set;
      wb_carry_clear_o    <= cy_any.clear;
      wb_overflow_set_o   <= ov_any.set;
      wb_overflow_clear_o <= ov_any.clear;
    end
  end

  a_rdy_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({alu.rdy, mul.rdy, div.rdy}));

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench, success only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_exec -o tb_exec_sim &&
./obj_dir/tb_exec_sim | tee /dev/stderr | grep -q "^RESULT: PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- test/tb_exec.sv
`timescale 1ns/1ps
/* testbench for exec_top that runs one unit at a time so write-backs never overlap
   expected results queue in issue order and are checked one edge after each write-back */
module tb_exec;
  import exec_opc_pkg::*;

  localparam int OW         = 32;
  localparam int SHW        = $clog2(OW);
  localparam int CLK_PERIOD = 10;
  localparam int ALU_REPS   = 6;
  localparam int N_MUL      = 40;
  localparam int N_DIV      = 20;
  localparam int N_OPS      = ALU_REPS * 16 + 60 + N_MUL + N_DIV + 3;
  localparam logic [OW-1:0] SMIN = {1'b1, {(OW-1){1'b0}}};
  localparam logic [OW-1:0] SMAX = {1'b0, {(OW-1){1'b1}}};

  logic clk = 1'b0;
  logic rst;
  logic padv_wb_i, pipeline_flush_i, insn_1clk_i, immediate_sel_i;
  logic carry_i, flag_i, op_mul_i, op_div_i, div_signed_i;
  logic [OW-1:0] rfa_i, rfb_i, immediate_i;
  alu_op_e alu_op_i;
  cmp_op_e cmp_op_i;
  logic mul_busy_o, take_op_mul_o, div_busy_o, take_op_div_o, exec_valid_o;
  logic [OW-1:0] wb_result_o;
  logic wb_int_flag_set_o, wb_int_flag_clear_o, wb_carry_set_o, wb_carry_clear_o;
  logic wb_overflow_set_o, wb_overflow_clear_o;

  // {int set, int clear, carry set, carry clear, ovf set, ovf clear, result}
  logic [OW+5:0] exp_q[$];
  logic [OW+5:0] exp_entry = '0;
  logic [OW-1:0] got_result = '0;
  logic [5:0]    got_flags = '0;
  logic          wb_due = 1'b0;
  logic          chk_en = 1'b0;
  logic          stray_wb = 1'b0;
  logic [31:0]   rng_state = 32'd42;

  exec_top #(.OPERAND_WIDTH(OW)) UUT (.*);

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // boundary values mixed into the random operands
  function automatic logic [OW-1:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0: return SMIN;
      3'd1: return SMAX;
      3'd2: return '1;
      3'd3: return OW'(r[7:3]);  // small enough to serve as a shift amount
      default: return OW'(next_rand());
    endcase
  endfunction

  function automatic logic [OW+5:0] alu_model(input alu_op_e op, input cmp_op_e cmp,
      input logic [OW-1:0] a, input logic [OW-1:0] b, input logic [OW-1:0] imm,
      input logic cin, input logic flg);
    logic [OW:0]   ext;
    logic [OW-1:0] res;
    logic [5:0]    fl;
    logic          cy;
    logic          ov;
    logic          cond;
    int            sh;
    res = '0;
    fl  = '0;
    sh  = int'(b[SHW-1:0]);
    case (op)
      ADD, ADDC: begin
        ext = {1'b0, a} + {1'b0, b} + {{OW{1'b0}}, cin & (op == ADDC)};
        res = ext[OW-1:0];
        cy  = ext[OW];
        ov  = (a[OW-1] == b[OW-1]) && (res[OW-1] != a[OW-1]);
        fl  = {2'b00, cy, ~cy, ov, ~ov};
      end
      SUB: begin
        res = a - b;
        cy  = (a >= b);  // no borrow
        ov  = (a[OW-1] != b[OW-1]) && (res[OW-1] != a[OW-1]);
        fl  = {2'b00, cy, ~cy, ov, ~ov};
      end
      AND: res = a & b;
      OR:  res = a | b;
      XOR: res = a ^ b;
      SLL: res = a << sh;
      SRL: res = a >> sh;
      SRA: res = OW'($signed(a) >>> sh);
      ROR: res = (a >> sh) | (a << (OW - sh));
      FF1: begin
        for (int i = 0; i < OW; i++) begin
          if (a[i] && res == '0)
            res = OW'(i + 1);
        end
      end
      FL1: begin
        for (int i = OW - 1; i >= 0; i--) begin
          if (a[i] && res == '0)
            res = OW'(i + 1);
        end
      end
      CMOV:  res = flg ? a : b;
      MOVHI: res = imm;
      SETFLAG: begin
        case (cmp)
          EQ:      cond = (a == b);
          NE:      cond = (a != b);
          GTU:     cond = (a > b);
          GTS:     cond = ($signed(a) > $signed(b));
          GEU:     cond = (a >= b);
          GES:     cond = ($signed(a) >= $signed(b));
          LTU:     cond = (a < b);
          LTS:     cond = ($signed(a) < $signed(b));
          LEU:     cond = (a <= b);
          LES:     cond = ($signed(a) <= $signed(b));
          default: cond = 1'b0;
        endcase
        fl = {cond, ~cond, 4'b0000};
      end
      default: res = '0;
    endcase
    return {fl, res};
  endfunction

  function automatic logic [OW+5:0] div_model(input logic [OW-1:0] a,
      input logic [OW-1:0] b, input logic sgn);
    logic          na;
    logic          nb;
    logic          dbz;
    logic [OW-1:0] q;
    na  = sgn & a[OW-1];
    nb  = sgn & b[OW-1];
    dbz = (b == '0);
    q   = dbz ? '1 : (na ? -a : a) / (nb ? -b : b);  // magnitudes
    if (na ^ nb)
      q = -q;
    return {2'b00, sgn ? 2'b00 : {dbz, ~dbz}, sgn ? {dbz, ~dbz} : 2'b00, q};
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input logic padv);
    padv_wb_i        = padv;
    pipeline_flush_i = 1'b0;
    insn_1clk_i      = 1'b0;
    op_mul_i         = 1'b0;
    op_div_i         = 1'b0;
  endtask

  task automatic issue_alu(input alu_op_e op, input cmp_op_e cmp, input logic [OW-1:0] a,
      input logic [OW-1:0] b, input logic sel);
    logic [31:0]   r;
    logic [OW-1:0] other;
    r               = next_rand();
    other           = OW'(next_rand());
    rfa_i           = a;
    rfb_i           = sel ? other : b;
    immediate_i     = sel ? b : other;
    immediate_sel_i = sel;
    alu_op_i        = op;
    cmp_op_i        = cmp;
    carry_i         = r[0];
    flag_i          = r[1];
    insn_1clk_i     = 1'b1;
    padv_wb_i       = 1'b1;
    exp_q.push_back(alu_model(op, cmp, a, b, immediate_i, carry_i, flag_i));
    step();
  endtask

  task automatic run_muls(input int count);
    int            issued;
    logic [31:0]   r;
    logic [OW-1:0] a;
    logic [OW-1:0] b;
    logic [OW-1:0] opb;
    issued = 0;
    a = pick_operand();
    b = pick_operand();
    while (issued < count) begin
      r               = next_rand();
      rfa_i           = a;
      rfb_i           = b;
      immediate_i     = ~b;
      immediate_sel_i = r[3];
      op_mul_i        = 1'b1;
      padv_wb_i       = (r[1:0] != 2'b00);  // stall about one cycle in four
      #3;
      if (take_op_mul_o) begin
        opb = immediate_sel_i ? immediate_i : rfb_i;
        exp_q.push_back({6'b0, a * opb});
        issued++;
        a = pick_operand();
        b = pick_operand();
      end
      step();
    end
    op_mul_i = 1'b0;
  endtask

  task automatic run_div(input logic [OW-1:0] a, input logic [OW-1:0] b, input logic sgn);
    logic [31:0] r;
    rfa_i        = a;
    rfb_i        = b;
    div_signed_i = sgn;
    op_div_i     = 1'b1;
    padv_wb_i    = 1'b1;
    #3;
    while (!take_op_div_o) begin
      step();
      #3;
    end
    exp_q.push_back(div_model(a, b, sgn));
    step();
    rfa_i    = OW'(next_rand());  // divider must have latched its operands
    rfb_i    = OW'(next_rand());
    step();                       // busy divider refuses a repeated request
    op_div_i = 1'b0;
    while (exp_q.size() != 0) begin
      r         = next_rand();
      padv_wb_i = r[0] | r[1];
      step();
    end
  endtask

  task automatic flush_muls();
    idle(1'b1);
    rfa_i           = OW'(next_rand());
    rfb_i           = OW'(next_rand());
    immediate_sel_i = 1'b0;
    op_mul_i        = 1'b1;
    step();
    step();
    idle(1'b0);  // first product waits in the last stage
    step();
    pipeline_flush_i = 1'b1;
    padv_wb_i        = 1'b1;
    step();
    idle(1'b1);
    repeat (8) step();
  endtask

  task automatic flush_div();
    idle(1'b1);
    rfa_i        = OW'(next_rand());
    rfb_i        = OW'(next_rand());
    div_signed_i = 1'b1;
    op_div_i     = 1'b1;
    step();
    idle(1'b1);
    repeat (OW / 2) step();
    pipeline_flush_i = 1'b1;
    step();
    idle(1'b1);
    repeat (OW + 4) step();
  endtask

  task automatic drain();
    idle(1'b1);
    while (exp_q.size() != 0)
      step();
    step();
  endtask

  // write-back edge is predicted from stable pre-edge values
  always @(negedge clk) begin
    chk_en   = 1'b0;
    stray_wb = 1'b0;
    if (wb_due) begin
      if (exp_q.size() == 0) begin
        stray_wb = 1'b1;
      end else begin
        exp_entry  = exp_q.pop_front();
        got_result = wb_result_o;
        got_flags  = {wb_int_flag_set_o, wb_int_flag_clear_o, wb_carry_set_o,
                      wb_carry_clear_o, wb_overflow_set_o, wb_overflow_clear_o};
        chk_en     = 1'b1;
      end
    end
    wb_due = padv_wb_i && exec_valid_o && !pipeline_flush_i && !rst;
  end

  a_wb_result: assert property (@(posedge clk) chk_en |-> got_result == exp_entry[OW-1:0])
    else begin
      $display("ERR wb_result_o exp %h got %h", exp_entry[OW-1:0], got_result);
      $display("RESULT: FAIL");
      $fatal(1, "result mismatch");
    end

  a_wb_flags: assert property (@(posedge clk) chk_en |-> got_flags == exp_entry[OW+5:OW])
    else begin
      $display("ERR wb_int_flag/wb_carry/wb_overflow set,clear exp %h got %h",
               exp_entry[OW+5:OW], got_flags);
      $display("RESULT: FAIL");
      $fatal(1, "flag mismatch");
    end

  a_no_stray: assert property (@(posedge clk) !stray_wb)
    else begin
      $display("a write-back happened with no operation pending");
      $display("RESULT: FAIL");
      $fatal(1, "unexpected write-back");
    end

  a_mul_stall: assert property (@(posedge clk) disable iff (rst)
    op_mul_i && exec_valid_o && !padv_wb_i |-> mul_busy_o && !take_op_mul_o)
    else begin
      $display("multiplier accepted or was not busy while a product waited");
      $display("RESULT: FAIL");
      $fatal(1, "multiplier stall");
    end

  a_div_busy: assert property (@(posedge clk) disable iff (rst)
    div_busy_o && !pipeline_flush_i |=> div_busy_o || exec_valid_o)
    else begin
      $display("divider dropped busy before its result was ready");
      $display("RESULT: FAIL");
      $fatal(1, "divider busy");
    end

  a_div_take: assert property (@(posedge clk) disable iff (rst)
    op_div_i && div_busy_o |-> !take_op_div_o)
    else begin
      $display("divider accepted a new operation while busy");
      $display("RESULT: FAIL");
      $fatal(1, "divider take");
    end

  // reset and flush both leave the stage empty one edge later
  a_quiet: assert property (@(posedge clk) rst || pipeline_flush_i |=>
    !mul_busy_o && !div_busy_o && !exec_valid_o && wb_result_o == '0 &&
    !wb_int_flag_set_o && !wb_int_flag_clear_o && !wb_carry_set_o &&
    !wb_carry_clear_o && !wb_overflow_set_o && !wb_overflow_clear_o)
    else begin
      $display("busy, valid, result or flag output not cleared after reset or flush");
      $display("RESULT: FAIL");
      $fatal(1, "not cleared");
    end

  initial begin
    #(CLK_PERIOD * N_OPS * (OW + 8));
    $display("watchdog expired before all operations wrote back");
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    logic [OW-1:0] a;
    logic [OW-1:0] b;
    logic [31:0]   r;
    rst = 1'b1;
    idle(1'b0);
    rfa_i           = '0;
    rfb_i           = '0;
    immediate_i     = '0;
    immediate_sel_i = 1'b0;
    alu_op_i        = NOP;
    cmp_op_i        = EQ;
    carry_i         = 1'b0;
    flag_i          = 1'b0;
    div_signed_i    = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    step();

    for (int i = 0; i < ALU_REPS; i++) begin
      for (int o = 0; o < 16; o++) begin
        a = pick_operand();
        b = pick_operand();
        issue_alu(alu_op_e'(o), cmp_op_e'(next_rand() % 10), a, b, i[0]);
      end
    end
    drain();

    for (int c = 0; c < 10; c++) begin
      for (int k = 0; k < 6; k++) begin
        a = pick_operand();
        b = pick_operand();
        case (k)
          1: b = a;
          2: begin
            a = SMIN;
            b = SMAX;
          end
          3: begin
            a = SMAX;
            b = SMIN;
          end
          4: begin
            a = '1;
            b = OW'(1);
          end
          5: begin
            a = '0;
            b = '1;
          end
          default: ;
        endcase
        issue_alu(SETFLAG, cmp_op_e'(c), a, b, k[0]);
      end
    end
    drain();

    run_muls(N_MUL);
    drain();

    run_div(OW'(100), OW'(7), 1'b0);
    run_div(OW'(-100), OW'(7), 1'b1);
    run_div(OW'(100), OW'(-7), 1'b1);
    run_div(OW'(-100), OW'(-7), 1'b1);
    run_div(OW'(1234), '0, 1'b0);  // zero divisor raises carry
    run_div(OW'(-5), '0, 1'b1);    // zero divisor raises overflow
    run_div(OW'(5), '0, 1'b1);
    run_div(SMIN, '1, 1'b1);
    run_div('1, OW'(1), 1'b0);
    run_div(OW'(-100), OW'(7), 1'b0);
    for (int i = 10; i < N_DIV; i++) begin
      r = next_rand();
      a = pick_operand();
      b = OW'(next_rand()) >> r[4:0];
      run_div(a, b, r[5]);
    end
    drain();

    flush_muls();
    flush_div();
    drain();

    if (exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("operations still pending at the end of the run");
      $display("RESULT: FAIL");
      $fatal(1, "pending operations");
    end
  end

endmodule
